// File: all.f
common/pkg_cache.sv
cache/cache_control.sv
cache/cache_datapath.sv
cache/plru_array.sv
hw/cache_top.sv
bench/cache_checker.sv
bench/cache_tb.sv

// File: bench/cache_tb.sv
module cache_tb
import pkg_cache::*;
();

    localparam int CLK_PERIOD        = 4;
    localparam int RANDOM_OPS        = 300;
    localparam int DIRECTED_REQUESTS = 12;
    // two fills of five cycles plus four cycles of control
    localparam int WORST_MISS        = 2 * 5 + 4;
    localparam int WATCHDOG_TIME     =
        (DIRECTED_REQUESTS + RANDOM_OPS) * WORST_MISS * 2 * CLK_PERIOD + 16 * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst;
    logic       mem_read;
    logic       mem_write;
    addr_t      mem_address;
    word_t      mem_wdata;
    logic [3:0] mem_byte_enable;
    logic       mem_resp;
    word_t      mem_rdata;
    logic       pmem_read;
    logic       pmem_write;
    addr_t      pmem_address;
    line_t      pmem_wdata;
    logic       pmem_resp;
    line_t      pmem_rdata;

    // reference view of memory and a shadow of the tag state
    logic [7:0]  ref_mem [addr_t];
    line_t       pmem_lines [addr_t];
    logic [23:0] sh_tag [8][4];
    logic        sh_valid [8][4];
    logic        sh_dirty [8][4];
    logic [2:0]  sh_plru [8];

    word_t       rd_q [$];
    addr_t       fill_q [$];
    addr_t       wb_addr_q [$];
    line_t       wb_line_q [$];

    logic [31:0] lcg_state = 32'd59837;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    int          pmem_requests = 0;
    int          last_latency;
    int          assert_fails;
    string       cur_test;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top #(
        .S_INDEX (3)
    ) i_cache_top (
        .clk             (clk),
        .rst             (rst),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_resp        (mem_resp),
        .mem_rdata       (mem_rdata),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_resp       (pmem_resp),
        .pmem_rdata      (pmem_rdata)
    );

    // ======================================================================
    // helpers and reference model
    // ======================================================================

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic word_t pattern_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ (a >> 11);
    endfunction

    function automatic line_t pattern_line(input addr_t line_addr);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = pattern_word(line_addr + 4 * i);
        end
        return l;
    endfunction

    function automatic logic [7:0] ref_byte(input addr_t a);
        word_t w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = pattern_word({a[31:2], 2'b00});
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic addr_t make_addr(input logic [23:0] tag, input logic [2:0] set,
                                        input logic [2:0] wsel);
        return {tag, set, wsel, 2'b00};
    endfunction

    function automatic void ref_access(
        input  logic       wr,
        input  addr_t      addr,
        input  word_t      wdata,
        input  logic [3:0] be,
        output word_t      rd,
        output logic       miss,
        output logic       wb,
        output addr_t      wb_addr,
        output line_t      wb_line
    );
        logic [2:0]  set;
        logic [23:0] tag;
        logic [2:0]  bits;
        int          way;
        set     = addr[7:5];
        tag     = addr[31:8];
        bits    = sh_plru[set];
        miss    = 1'b1;
        wb      = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        way     = 0;
        for (int w = 0; w < 4; w++) begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag) begin
                miss = 1'b0;
                way  = w;
            end
        end
        if (miss) begin
            // root bit 0 means the left pair holds the victim
            if (bits[0] == 1'b0) begin
                way = bits[1] ? 1 : 0;
            end else begin
                way = bits[2] ? 3 : 2;
            end
            if (sh_valid[set][way] && sh_dirty[set][way]) begin
                wb      = 1'b1;
                wb_addr = {sh_tag[set][way], set, 5'b00000};
                for (int i = 0; i < 32; i++) begin
                    wb_line[i*8 +: 8] = ref_byte(wb_addr + i);
                end
            end
            sh_valid[set][way] = 1'b1;
            sh_tag[set][way]   = tag;
            sh_dirty[set][way] = 1'b0;
        end
        // tree bits point away from the way just used
        if (way < 2) begin
            bits[0] = 1'b1;
            bits[1] = (way == 0);
        end else begin
            bits[0] = 1'b0;
            bits[2] = (way == 2);
        end
        sh_plru[set] = bits;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[{addr[31:2], 2'b00} + b] = wdata[b*8 +: 8];
                end
            end
            sh_dirty[set][way] = 1'b1;
        end
        for (int b = 0; b < 4; b++) begin
            rd[b*8 +: 8] = ref_byte({addr[31:2], 2'b00} + b);
        end
    endfunction

    task automatic compare_word(input string what, input word_t exp, input word_t act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_addr(input string what, input addr_t exp, input addr_t act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_line(input string what, input line_t exp, input line_t act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("%s: ok, %0d checks", cur_test, test_checks);
        end else begin
            $display("%s: %0d problems in %0d checks", cur_test, test_errors, test_checks);
        end
    endtask

    // called one time unit after a rising edge, returns at the same phase
    task automatic cpu_access(input logic wr, input addr_t addr, input word_t wdata,
                              input logic [3:0] be);
        word_t exp_rd;
        logic  miss;
        logic  wb;
        addr_t wb_addr;
        line_t wb_line;
        ref_access(wr, addr, wdata, be, exp_rd, miss, wb, wb_addr, wb_line);
        if (wb) begin
            wb_addr_q.push_back(wb_addr);
            wb_line_q.push_back(wb_line);
        end
        if (miss) begin
            fill_q.push_back({addr[31:5], 5'b00000});
        end
        if (!wr) begin
            rd_q.push_back(exp_rd);
        end
        mem_read        = !wr;
        mem_write       = wr;
        mem_address     = addr;
        mem_wdata       = wdata;
        mem_byte_enable = be;
        last_latency    = 0;
        do begin
            @(posedge clk);
            last_latency++;
        end while (!mem_resp);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // ======================================================================
    // physical memory model and response checks
    // ======================================================================

    initial begin
        int delay;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(posedge clk);
            if (!rst && (pmem_read || pmem_write)) begin
                pmem_requests++;
                delay = 2 + lcg_next() % 4;
                repeat (delay - 1) @(posedge clk);
                #1;
                if (pmem_write) begin
                    pmem_lines[pmem_address] = pmem_wdata;
                end else if (pmem_lines.exists(pmem_address)) begin
                    pmem_rdata = pmem_lines[pmem_address];
                end else begin
                    pmem_rdata = pattern_line(pmem_address);
                end
                pmem_resp = 1'b1;
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (mem_resp && mem_read) begin
                if (rd_q.size() == 0) begin
                    report_problem("read response arrived that no request expected");
                end else begin
                    compare_word("read data", rd_q.pop_front(), mem_rdata);
                end
            end
            if (pmem_resp && pmem_read) begin
                if (fill_q.size() == 0) begin
                    report_problem("line fill happened on a hit");
                end else begin
                    compare_addr("fill address", fill_q.pop_front(), pmem_address);
                end
            end
            if (pmem_resp && pmem_write) begin
                if (wb_addr_q.size() == 0) begin
                    report_problem("writeback happened without a dirty victim");
                end else begin
                    compare_addr("writeback address", wb_addr_q.pop_front(), pmem_address);
                    compare_line("writeback line", wb_line_q.pop_front(), pmem_wdata);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the cache stopped answering requests, run stopped");
        $display("TEST FAILED");
        $finish;
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    initial begin
        logic [15:0] r;
        logic [15:0] r2;
        int          req_before;
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        cur_test        = "reset";
        for (int s = 0; s < 8; s++) begin
            sh_plru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("read_miss_fill");
        cpu_access(1'b0, make_addr(24'h000123, 3'd2, 3'd5), '0, 4'b1111);
        report_test();

        start_test("read_hit");
        req_before = pmem_requests;
        cpu_access(1'b0, make_addr(24'h000123, 3'd2, 3'd1), '0, 4'b1111);
        if (pmem_requests != req_before) begin
            report_problem("a physical request was issued for a read hit");
        end
        if (last_latency != 2) begin
            report_problem($sformatf("read hit took %0d cycles instead of 2", last_latency));
        end
        report_test();

        start_test("byte_write_hit");
        cpu_access(1'b1, make_addr(24'h000123, 3'd2, 3'd5), 32'hdead_beef, 4'b0101);
        cpu_access(1'b0, make_addr(24'h000123, 3'd2, 3'd5), '0, 4'b1111);
        report_test();

        // fill all four ways, touch two of them, then force a dirty eviction
        start_test("dirty_evict_plru");
        for (int n = 0; n < 4; n++) begin
            cpu_access(1'b1, make_addr(24'h000a00 + 24'(n), 3'd5, 3'(n)),
                       32'h1111_0000 + n, 4'b1111);
        end
        cpu_access(1'b1, make_addr(24'h000a01, 3'd5, 3'd7), 32'h2222_3333, 4'b1100);
        cpu_access(1'b0, make_addr(24'h000a00, 3'd5, 3'd0), '0, 4'b1111);
        cpu_access(1'b1, make_addr(24'h000a04, 3'd5, 3'd2), 32'h4444_5555, 4'b0011);
        cpu_access(1'b0, make_addr(24'h000a04, 3'd5, 3'd2), '0, 4'b1111);
        report_test();

        start_test("random_mix");
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r  = lcg_next();
            r2 = lcg_next();
            cpu_access(r[0], make_addr(24'h000040 + 24'(r[14:5] % 6), {2'b00, r[1]}, r[4:2]),
                       {r2, lcg_next()}, (r2[3:0] == 4'b0000) ? 4'b1111 : r2[3:0]);
        end
        report_test();

        if (rd_q.size() != 0 || fill_q.size() != 0 || wb_addr_q.size() != 0) begin
            report_problem("some expected reads, fills or writebacks never happened");
        end
        assert_fails = i_cache_top.i_cache_control.i_cache_checker.assert_fails;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : cache_tb

// File: bench/cache_checker.sv
module cache_checker (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    // read by the testbench at the end of the run
    int assert_fails = 0;

    // memory port carries one direction at a time
    a_pmem_excl: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else begin
            assert_fails++;
            $error("pmem_read and pmem_write high together");
        end

    a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
        else begin
            assert_fails++;
            $error("mem_resp without a cpu request");
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!pmem_read && !pmem_write))
        else begin
            assert_fails++;
            $error("pmem request active right after reset");
        end

    // a pending request is held until memory answers
    a_read_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> pmem_read)
        else begin
            assert_fails++;
            $error("pmem_read dropped before pmem_resp");
        end

    a_write_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_write && !pmem_resp) |=> pmem_write)
        else begin
            assert_fails++;
            $error("pmem_write dropped before pmem_resp");
        end

endmodule : cache_checker

bind cache_control cache_checker i_cache_checker (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp)
);

// File: hw/cache_top.sv
module cache_top
import pkg_cache::*;
#(
    parameter int S_INDEX = 3
)
(
    input  logic                      clk,
    input  logic                      rst,

    // cpu port
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  addr_t                     mem_address,
    input  word_t                     mem_wdata,
    input  logic [BYTES_PER_WORD-1:0] mem_byte_enable,
    output logic                      mem_resp,
    output word_t                     mem_rdata,

    // physical memory port
    output logic                      pmem_read,
    output logic                      pmem_write,
    output addr_t                     pmem_address,
    output line_t                     pmem_wdata,
    input  logic                      pmem_resp,
    input  line_t                     pmem_rdata
);

    logic               hit;
    logic               dirty;
    logic               ld_valid;
    logic               ld_dirty;
    logic               ld_tag;
    logic               ld_data;
    logic               ld_plru;
    logic               dirty_val;
    waymux_t            dirty_wmux;
    waymux_t            data_wmux;
    waymux_t            plru_wmux;
    datamux_t           data_mux;
    pmadmux_t           pmad_mux;
    way_t               hit_way;
    way_t               lru_way;
    logic [S_INDEX-1:0] set_index;

    cache_control i_cache_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .hit        (hit),
        .dirty      (dirty),
        .ld_valid   (ld_valid),
        .ld_dirty   (ld_dirty),
        .ld_tag     (ld_tag),
        .ld_data    (ld_data),
        .ld_plru    (ld_plru),
        .dirty_val  (dirty_val),
        .dirty_wmux (dirty_wmux),
        .data_wmux  (data_wmux),
        .plru_wmux  (plru_wmux),
        .data_mux   (data_mux),
        .pmad_mux   (pmad_mux)
    );

    cache_datapath #(
        .S_INDEX (S_INDEX)
    ) i_cache_datapath (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .ld_valid        (ld_valid),
        .ld_dirty        (ld_dirty),
        .ld_tag          (ld_tag),
        .ld_data         (ld_data),
        .dirty_val       (dirty_val),
        .dirty_wmux      (dirty_wmux),
        .data_wmux       (data_wmux),
        .data_mux        (data_mux),
        .pmad_mux        (pmad_mux),
        .lru_way         (lru_way),
        .hit_way         (hit_way),
        .set_index       (set_index),
        .hit             (hit),
        .dirty           (dirty)
    );

    plru_array #(
        .S_INDEX (S_INDEX)
    ) i_plru_array (
        .clk       (clk),
        .rst       (rst),
        .ld_plru   (ld_plru),
        .plru_wmux (plru_wmux),
        .set_index (set_index),
        .hit_way   (hit_way),
        .lru_way   (lru_way)
    );

endmodule : cache_top

// File: cache/plru_array.sv
module plru_array
import pkg_cache::*;
#(
    parameter int S_INDEX = 3
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ld_plru,
    input  waymux_t            plru_wmux,
    input  logic [S_INDEX-1:0] set_index,
    input  way_t               hit_way,
    output way_t               lru_way
);

    localparam int NUM_SETS = 2 ** S_INDEX;

    // bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    logic [NUM_SETS-1:0][2:0] plru_bits;
    logic [2:0]               cur_bits;
    logic [2:0]               next_bits;
    way_t                     access_way;

    assign cur_bits = plru_bits[set_index];

    // root picks the half, that half's bit picks the way
    assign lru_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

    assign access_way = (plru_wmux == W_HIT) ? hit_way : lru_way;

    // point every bit on the accessed path away from it
    always_comb begin
        next_bits    = cur_bits;
        next_bits[0] = ~access_way[1];
        if (access_way[1]) begin
            next_bits[2] = ~access_way[0];
        end else begin
            next_bits[1] = ~access_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            plru_bits <= '0;
        end else if (ld_plru) begin
            plru_bits[set_index] <= next_bits;
        end
    end

endmodule : plru_array

// File: cache/cache_datapath.sv
module cache_datapath
import pkg_cache::*;
#(
    parameter int S_INDEX = 3
)
(
    input  logic                      clk,
    input  logic                      rst,

    // cpu side
    input  addr_t                     mem_address,
    input  word_t                     mem_wdata,
    input  logic [BYTES_PER_WORD-1:0] mem_byte_enable,
    output word_t                     mem_rdata,

    // physical memory side
    input  line_t                     pmem_rdata,
    output addr_t                     pmem_address,
    output line_t                     pmem_wdata,

    // controls
    input  logic                      ld_valid,
    input  logic                      ld_dirty,
    input  logic                      ld_tag,
    input  logic                      ld_data,
    input  logic                      dirty_val,
    input  waymux_t                   dirty_wmux,
    input  waymux_t                   data_wmux,
    input  datamux_t                  data_mux,
    input  pmadmux_t                  pmad_mux,

    // replacement
    input  way_t                      lru_way,
    output way_t                      hit_way,
    output logic [S_INDEX-1:0]        set_index,

    // status
    output logic                      hit,
    output logic                      dirty
);

    localparam int TAG_BITS      = ADDR_WIDTH - S_INDEX - OFFSET_BITS;
    localparam int NUM_SETS      = 2 ** S_INDEX;
    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);

    // ===================================================================
    // arrays
    // ===================================================================

    logic [TAG_BITS-1:0]               tag_arr  [NUM_WAYS][NUM_SETS];
    line_t                             data_arr [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_bits;

    logic [TAG_BITS-1:0]      cpu_tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    line_t                    hit_line;
    line_t                    merged_line;
    line_t                    data_in;
    logic [TAG_BITS-1:0]      victim_tag;
    way_t                     data_way;
    way_t                     dirty_way;

    // address fields
    assign cpu_tag   = mem_address[ADDR_WIDTH-1 -: TAG_BITS];
    assign set_index = mem_address[OFFSET_BITS +: S_INDEX];
    assign word_sel  = mem_address[OFFSET_BITS-1 -: WORD_SEL_BITS];

    // all four ways compared in parallel
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_bits[w][set_index] && tag_arr[w][set_index] == cpu_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign dirty = valid_bits[lru_way][set_index] & dirty_bits[lru_way][set_index];

    // ===================================================================
    // cpu read and byte merge
    // ===================================================================

    assign hit_line  = data_arr[hit_way][set_index];
    assign mem_rdata = hit_line[word_sel*WORD_WIDTH +: WORD_WIDTH];

    always_comb begin
        merged_line = hit_line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (word_sel == WORD_SEL_BITS'(i) && mem_byte_enable[b]) begin
                    merged_line[i*WORD_WIDTH + b*8 +: 8] = mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign data_in   = (data_mux == D_LLC) ? pmem_rdata : merged_line;
    assign data_way  = (data_wmux == W_HIT) ? hit_way : lru_way;
    assign dirty_way = (dirty_wmux == W_HIT) ? hit_way : lru_way;

    // ===================================================================
    // physical memory side
    // ===================================================================

    assign victim_tag = tag_arr[lru_way][set_index];
    assign pmem_wdata = data_arr[lru_way][set_index];

    always_comb begin
        if (pmad_mux == P_CACHE) begin
            pmem_address = {victim_tag, set_index, {OFFSET_BITS{1'b0}}};
        end else begin
            pmem_address = {mem_address[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

    // ===================================================================
    // array writes
    // ===================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            // a fill always targets the victim way
            if (ld_valid) begin
                valid_bits[lru_way][set_index] <= 1'b1;
            end
            if (ld_dirty) begin
                dirty_bits[dirty_way][set_index] <= dirty_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_tag) begin
            tag_arr[lru_way][set_index] <= cpu_tag;
        end
        if (ld_data) begin
            data_arr[data_way][set_index] <= data_in;
        end
    end

endmodule : cache_datapath

// File: cache/cache_control.sv
module cache_control
import pkg_cache::*;
(
    input  logic     clk,
    input  logic     rst,

    // cpu and physical memory handshakes
    input  logic     mem_read,
    input  logic     mem_write,
    input  logic     pmem_resp,
    output logic     mem_resp,
    output logic     pmem_read,
    output logic     pmem_write,

    // status from the datapath
    input  logic     hit,
    input  logic     dirty,

    // array strobes and selects
    output logic     ld_valid,
    output logic     ld_dirty,
    output logic     ld_tag,
    output logic     ld_data,
    output logic     ld_plru,
    output logic     dirty_val,
    output waymux_t  dirty_wmux,
    output waymux_t  data_wmux,
    output waymux_t  plru_wmux,
    output datamux_t data_mux,
    output pmadmux_t pmad_mux
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,
        S_EVICT,
        S_LOAD
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ===================================================================
    // next state
    // ===================================================================

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (mem_read || mem_write) begin
                    next_state = S_COMPARE;
                end
            end
            S_COMPARE: begin
                if (hit) begin
                    next_state = S_IDLE;
                end else if (dirty) begin
                    next_state = S_EVICT;
                end else begin
                    next_state = S_LOAD;
                end
            end
            S_EVICT: begin
                if (pmem_resp) begin
                    next_state = S_LOAD;
                end
            end
            S_LOAD: begin
                // refilled line is checked again in compare
                if (pmem_resp) begin
                    next_state = S_COMPARE;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    // ===================================================================
    // state actions
    // ===================================================================

    always_comb begin
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        ld_valid   = 1'b0;
        ld_dirty   = 1'b0;
        ld_tag     = 1'b0;
        ld_data    = 1'b0;
        ld_plru    = 1'b0;
        dirty_val  = 1'b0;
        dirty_wmux = W_HIT;
        data_wmux  = W_HIT;
        plru_wmux  = W_HIT;
        data_mux   = D_CPU;
        pmad_mux   = P_CPU;

        case (state)
            S_COMPARE: begin
                if (hit) begin
                    mem_resp  = 1'b1;
                    ld_plru   = 1'b1;
                    plru_wmux = W_HIT;
                    if (mem_write) begin
                        // merge cpu bytes into the hit line and mark it dirty
                        ld_data    = 1'b1;
                        data_wmux  = W_HIT;
                        data_mux   = D_CPU;
                        ld_dirty   = 1'b1;
                        dirty_wmux = W_HIT;
                        dirty_val  = 1'b1;
                    end
                end
            end
            S_EVICT: begin
                pmem_write = 1'b1;
                pmad_mux   = P_CACHE;
            end
            S_LOAD: begin
                pmem_read = 1'b1;
                pmad_mux  = P_CPU;
                // fill lands in the victim way only when the line arrives
                if (pmem_resp) begin
                    ld_tag     = 1'b1;
                    ld_valid   = 1'b1;
                    ld_data    = 1'b1;
                    data_wmux  = W_LRU;
                    data_mux   = D_LLC;
                    ld_dirty   = 1'b1;
                    dirty_wmux = W_LRU;
                    dirty_val  = 1'b0;
                    ld_plru    = 1'b1;
                    plru_wmux  = W_LRU;
                end
            end
            default: ;
        endcase
    end

endmodule : cache_control

// File: common/pkg_cache.sv
package pkg_cache;

    // ===================================================================
    // widths and geometry
    // ===================================================================

    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 256;
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;
    localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;

    // byte offset inside a 32-byte line
    localparam int OFFSET_BITS = 5;

    // tree pseudo-LRU below is written for exactly four ways
    localparam int NUM_WAYS = 4;
    localparam int WAY_BITS = $clog2(NUM_WAYS);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [WAY_BITS-1:0]   way_t;

    // ===================================================================
    // select encodings shared by controller and datapath
    // ===================================================================

    // which way an array write goes to
    typedef enum logic {
        W_HIT,
        W_LRU
    } waymux_t;

    // source of the line written into the data array
    typedef enum logic {
        D_CPU,
        D_LLC
    } datamux_t;

    // physical memory address source
    typedef enum logic {
        P_CPU,
        P_CACHE
    } pmadmux_t;

endpackage : pkg_cache
